// ==== design/adc_frontend.sv ====
/*
  one register stage from raw code to two's complement, loopback muxed before it
  raw code is negative slope, converted by keeping the MSB and inverting the rest
*/
`timescale 1ns/1ps
`default_nettype none

module adc_frontend #(
  parameter int SMP_W = 14
) (
  input  wire             adc_clk,
  input  wire             arst_n_i,
  input  afe_pkg::code_t  adc_dat_a_i, // CH1 raw
  input  afe_pkg::code_t  adc_dat_b_i, // CH2 raw
  input  afe_pkg::smp_t   loop_a_i, // saturated DAC value
  input  afe_pkg::smp_t   loop_b_i,
  input  logic            digital_loop_i,
  output afe_pkg::smp_t   adc_a_o,
  output afe_pkg::smp_t   adc_b_o
);

  afe_pkg::smp_t conv_a; // converted raw codes
  afe_pkg::smp_t conv_b;

  // negative slope code to two's complement
  assign conv_a = {adc_dat_a_i[SMP_W-1], ~adc_dat_a_i[SMP_W-2:0]};
  assign conv_b = {adc_dat_b_i[SMP_W-1], ~adc_dat_b_i[SMP_W-2:0]};

  //////////////////////////////
  // sample register
  //////////////////////////////

  // loopback taken at the same edge, so both paths see one cycle latency
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end
    else
    begin
      adc_a_o <= digital_loop_i ? loop_a_i : conv_a;
      adc_b_o <= digital_loop_i ? loop_b_i : conv_b;
    end
  end

endmodule

`default_nettype wire

// ==== design/afe_pkg.sv ====
/*
  shared widths, bus map and housekeeping offsets for the analog front end
  region field is 3 bits starting at REGION_LSB, so each region spans 1 MiB
*/
`default_nettype none

package afe_pkg;

  //////////////////////////////
  // sample widths
  //////////////////////////////

  parameter int SMP_W = 14; // ADC and DAC resolution

  typedef logic signed [SMP_W-1:0] smp_t; // two's complement sample
  typedef logic        [SMP_W-1:0] code_t; // raw converter code, negative slope

  //////////////////////////////
  // system bus
  //////////////////////////////

  parameter int BUS_AW = 32;
  parameter int BUS_DW = 32;

  parameter int N_REGIONS  = 8; // one-hot region selects
  parameter int REGION_LSB = 20; // region field is addr[22:20]

  //////////////////////////////
  // housekeeping (region 0)
  //////////////////////////////

  // offsets within region 0, word aligned
  typedef enum logic [REGION_LSB-1:0] {
    HK_ID   = 'h0, // read only
    HK_LOOP = 'h4, // bit 0 digital loopback
    HK_LED  = 'h8  // bits 7:0 LEDs
  } hk_reg_e;

  parameter logic [BUS_DW-1:0] HK_ID_VAL = 32'h0AFE_0001; // board id, rev 1

endpackage

`default_nettype wire

// ==== design/afe_top.sv ====
/*
  analog front end top, everything on adc_clk, no registers at this level
  asg and pid contributions come in from outside, converted ADC values go out
*/
`timescale 1ns/1ps
`default_nettype none

module afe_top (
  input  wire                              adc_clk,
  input  wire                              arst_n_i,
  // ADC
  input  afe_pkg::code_t                   adc_dat_a_i, // CH1 raw
  input  afe_pkg::code_t                   adc_dat_b_i, // CH2 raw
  output afe_pkg::smp_t                    adc_a_o,
  output afe_pkg::smp_t                    adc_b_o,
  // DAC contributions
  input  afe_pkg::smp_t                    asg_a_i,
  input  afe_pkg::smp_t                    asg_b_i,
  input  afe_pkg::smp_t                    pid_a_i,
  input  afe_pkg::smp_t                    pid_b_i,
  output afe_pkg::code_t                   dac_dat_a_o,
  output afe_pkg::code_t                   dac_dat_b_o,
  // LEDs
  output logic [7:0]                       led_o,
  // system bus
  input  logic [afe_pkg::BUS_AW-1:0]       sys_addr_i,
  input  logic [afe_pkg::BUS_DW-1:0]       sys_wdata_i,
  input  logic                             sys_wen_i,
  input  logic                             sys_ren_i,
  output logic [afe_pkg::BUS_DW-1:0]       sys_rdata_o,
  output logic                             sys_ack_o,
  output logic                             sys_err_o
);

  //////////////////////////////
  // local wires
  //////////////////////////////

  logic                        hk_wen;
  logic                        hk_ren;
  logic [afe_pkg::BUS_DW-1:0]  hk_rdata;
  logic                        hk_ack;
  logic                        hk_err;

  logic                        digital_loop; // from housekeeping
  afe_pkg::smp_t               dac_a; // saturated sums, fed back for loopback
  afe_pkg::smp_t               dac_b;

  //////////////////////////////
  // bus decode and housekeeping
  //////////////////////////////

  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err)
  );

  hk_regs i_hk_regs (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .addr_i         (sys_addr_i[afe_pkg::REGION_LSB-1:0]), // offset only
    .wdata_i        (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .err_o          (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  //////////////////////////////
  // sample paths
  //////////////////////////////

  adc_frontend #(
    .SMP_W (afe_pkg::SMP_W)
  ) i_adc_frontend (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .loop_a_i       (dac_a),
    .loop_b_i       (dac_b),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  dac_backend #(
    .SMP_W (afe_pkg::SMP_W)
  ) i_dac_backend (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .asg_a_i     (asg_a_i),
    .asg_b_i     (asg_b_i),
    .pid_a_i     (pid_a_i),
    .pid_b_i     (pid_b_i),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// ==== design/dac_backend.sv ====
/*
  asg + pid summed one bit wide, clamped to SMP_W bits, registered as DAC code
  dac_a_o and dac_b_o are combinational and meant for the loopback path
*/
`timescale 1ns/1ps
`default_nettype none

module dac_backend #(
  parameter int SMP_W = 14
) (
  input  wire             adc_clk,
  input  wire             arst_n_i,
  input  afe_pkg::smp_t   asg_a_i,
  input  afe_pkg::smp_t   asg_b_i,
  input  afe_pkg::smp_t   pid_a_i,
  input  afe_pkg::smp_t   pid_b_i,
  output afe_pkg::smp_t   dac_a_o, // saturated sum
  output afe_pkg::smp_t   dac_b_o,
  output afe_pkg::code_t  dac_dat_a_o, // to DAC pins
  output afe_pkg::code_t  dac_dat_b_o
);

  logic signed [SMP_W:0] sum_a; // one guard bit
  logic signed [SMP_W:0] sum_b;

  // clamp when guard and sign bits disagree
  function automatic logic [SMP_W-1:0] sat(input logic [SMP_W:0] s);
    if (s[SMP_W] != s[SMP_W-1])
      sat = {s[SMP_W], {(SMP_W-1){~s[SMP_W]}}}; // most positive / most negative
    else
      sat = s[SMP_W-1:0];
  endfunction

  // two's complement back to negative slope code
  function automatic logic [SMP_W-1:0] to_code(input logic [SMP_W-1:0] v);
    to_code = {v[SMP_W-1], ~v[SMP_W-2:0]};
  endfunction

  //////////////////////////////
  // sum and saturation
  //////////////////////////////

  assign sum_a = {asg_a_i[SMP_W-1], asg_a_i} + {pid_a_i[SMP_W-1], pid_a_i};
  assign sum_b = {asg_b_i[SMP_W-1], asg_b_i} + {pid_b_i[SMP_W-1], pid_b_i};

  assign dac_a_o = sat(sum_a);
  assign dac_b_o = sat(sum_b);

  // output register, new sample every cycle
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      dac_dat_a_o <= to_code(dac_a_o);
      dac_dat_b_o <= to_code(dac_b_o);
    end
  end

  // code keeps the true sign of last cycle's sum, also when clamped
  a_code_a : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    1'b1 |=> (dac_dat_a_o[SMP_W-1] == $past(sum_a[SMP_W]))
  );

  a_code_b : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    1'b1 |=> (dac_dat_b_o[SMP_W-1] == $past(sum_b[SMP_W]))
  );

endmodule

`default_nettype wire

// ==== design/hk_regs.sv ====
/*
  housekeeping registers, decodes only the offset bits, region is checked upstream
  acks every access on the next cycle, err on ID write or unknown offset
*/
`timescale 1ns/1ps
`default_nettype none

module hk_regs (
  input  wire                              adc_clk,
  input  wire                              arst_n_i,
  // bus, region 0 only
  input  logic [afe_pkg::REGION_LSB-1:0]   addr_i,
  input  logic [afe_pkg::BUS_DW-1:0]       wdata_i,
  input  logic                             wen_i,
  input  logic                             ren_i,
  output logic [afe_pkg::BUS_DW-1:0]       rdata_o,
  output logic                             ack_o,
  output logic                             err_o,
  // configuration
  output logic                             digital_loop_o,
  output logic [7:0]                       led_o
);

  logic                        addr_ok; // offset is one of hk_reg_e
  logic                        bad; // access gets err
  logic [afe_pkg::BUS_DW-1:0]  rd_mux;
  logic                        loop_q;
  logic [7:0]                  led_q;

  //////////////////////////////
  // offset decode
  //////////////////////////////

  always_comb
  begin
    addr_ok = 1'b1;
    rd_mux  = '0;
    case (addr_i)
      afe_pkg::HK_ID:   rd_mux = afe_pkg::HK_ID_VAL;
      afe_pkg::HK_LOOP: rd_mux = {{(afe_pkg::BUS_DW-1){1'b0}}, loop_q};
      afe_pkg::HK_LED:  rd_mux = {{(afe_pkg::BUS_DW-8){1'b0}}, led_q};
      default:          addr_ok = 1'b0;
    endcase
  end

  // ID is read only
  assign bad = !addr_ok || (wen_i && (addr_i == afe_pkg::HK_ID));

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end
    else if (wen_i && !bad)
    begin
      if (addr_i == afe_pkg::HK_LOOP)
        loop_q <= wdata_i[0];
      if (addr_i == afe_pkg::HK_LED)
        led_q <= wdata_i[7:0];
    end
  end

  // response, always one cycle after the strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      ack_o   <= wen_i | ren_i;
      err_o   <= (wen_i | ren_i) & bad;
      rdata_o <= (ren_i && addr_ok) ? rd_mux : '0; // zero on writes and errors
    end
  end

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

  // single-cycle ack, master never strobes during its own ack
  a_ack_pulse : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    ack_o |=> !ack_o
  );

endmodule

`default_nettype wire

// ==== design/sys_bus_decoder.sv ====
/*
  splits the bus into N_REGIONS by addr[REGION_LSB+:3], only region 0 is populated
  master must not raise wen and ren together nor strobe again before the ack
*/
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  wire                          adc_clk,
  input  wire                          arst_n_i,
  // master side
  input  logic [afe_pkg::BUS_AW-1:0]   sys_addr_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [afe_pkg::BUS_DW-1:0]   sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  // region 0, housekeeping
  output logic                         hk_wen_o,
  output logic                         hk_ren_o,
  input  logic [afe_pkg::BUS_DW-1:0]   hk_rdata_i,
  input  logic                         hk_ack_i,
  input  logic                         hk_err_i
);

  localparam int RG_W = $clog2(afe_pkg::N_REGIONS); // region field width

  logic [RG_W-1:0]               region; // addressed region index
  logic [afe_pkg::N_REGIONS-1:0] cs; // one-hot chip select
  logic                          strobe;
  logic [afe_pkg::N_REGIONS-1:0] sel_q; // region of the access in flight

  //////////////////////////////
  // address decode
  //////////////////////////////

  assign region = sys_addr_i[afe_pkg::REGION_LSB +: RG_W];
  assign cs     = afe_pkg::N_REGIONS'(1) << region;
  assign strobe = sys_wen_i | sys_ren_i;

  assign hk_wen_o = sys_wen_i & cs[0];
  assign hk_ren_o = sys_ren_i & cs[0];

  // remember who was addressed, one cycle only
  // for regions 1..7 this register is the ack itself
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      sel_q <= '0;
    else
      sel_q <= cs & {afe_pkg::N_REGIONS{strobe}};
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb
  begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    if (sel_q[0])
    begin
      sys_rdata_o = hk_rdata_i;
      sys_ack_o   = hk_ack_i;
      sys_err_o   = hk_err_i;
    end
    else if (|sel_q[afe_pkg::N_REGIONS-1:1])
    begin
      sys_ack_o = 1'b1; // empty slot, zero data and no error
    end
  end

  //////////////////////////////
  // protocol checks
  //////////////////////////////

  a_one_strobe : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i)
  );

  // covers region 0 too, so hk_regs latency is checked at the master port
  a_ack_after_strobe : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    strobe |=> sys_ack_o
  );

  a_no_stray_ack : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    sys_ack_o |-> $past(strobe)
  );

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+tests
design/afe_pkg.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/adc_frontend.sv
design/dac_backend.sv
design/afe_top.sv
tests/afe_tb.sv

// ==== tests/afe_tb_checks.svh ====
/*
  compare tasks and bus master for afe_tb, expects the DUT signals declared before include
  bus tasks wait for sys_ack_o with a cycle timeout, counts go to the closing summary
*/
`ifndef AFE_TB_CHECKS_SVH
`define AFE_TB_CHECKS_SVH

localparam int ACK_TMO = 16; // cycles to wait for an ack

int value_errs = 0; // wrong values seen
int proto_errs = 0; // missing, late or stretched acks

//////////////////////////////
// typed compares
//////////////////////////////

task automatic check_smp(input string name, input afe_pkg::smp_t got,
                         input afe_pkg::smp_t exp);
  if (got !== exp)
  begin
    $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    value_errs++;
  end
endtask

task automatic check_code(input string name, input afe_pkg::code_t got,
                          input afe_pkg::code_t exp);
  if (got !== exp)
  begin
    $display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    value_errs++;
  end
endtask

task automatic check_data(input string name, input logic [afe_pkg::BUS_DW-1:0] got,
                          input logic [afe_pkg::BUS_DW-1:0] exp);
  if (got !== exp)
  begin
    $display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    value_errs++;
  end
endtask

task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp)
  begin
    $display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    value_errs++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    value_errs++;
  end
endtask

//////////////////////////////
// bus master
//////////////////////////////

// one strobe cycle, then ack expected in the very next cycle
task automatic bus_access(input logic is_wr, input logic [afe_pkg::BUS_AW-1:0] addr,
                          input logic [afe_pkg::BUS_DW-1:0] wdata,
                          output logic [afe_pkg::BUS_DW-1:0] rdata, output logic err);
  int wait_cnt;
  @(posedge adc_clk);
  sys_addr_i  <= addr;
  sys_wdata_i <= wdata;
  sys_wen_i   <= is_wr;
  sys_ren_i   <= !is_wr;
  @(posedge adc_clk); // strobe sampled here
  sys_wen_i <= 1'b0;
  sys_ren_i <= 1'b0;
  wait_cnt = 0;
  @(negedge adc_clk); // middle of the ack cycle
  while (!sys_ack_o && wait_cnt < ACK_TMO)
  begin
    @(negedge adc_clk);
    wait_cnt++;
  end
  rdata = sys_rdata_o;
  err   = sys_err_o;
  if (!sys_ack_o)
  begin
    $display("bus access to 0x%h got no ack within %0d cycles", addr, ACK_TMO);
    proto_errs++;
  end
  else if (wait_cnt != 0)
  begin
    $display("bus access to 0x%h acked %0d cycles late", addr, wait_cnt);
    proto_errs++;
  end
  else
  begin
    @(negedge adc_clk);
    if (sys_ack_o)
    begin
      $display("ack for 0x%h stayed high for more than one cycle", addr);
      proto_errs++;
    end
  end
endtask

`endif

// ==== tests/afe_tb.sv ====
/*
  table driven testbench for afe_top, samples checked one cycle after they are presented
  expected values are built from the conversion and saturation rules, not from the DUT
*/
`timescale 1ns/1ps
`default_nettype none

module afe_tb;

  localparam int CLK_HALF = 4; // 8 ns period

  // lower bits of a code, flipped by the negative slope conversion
  localparam afe_pkg::code_t LOW_MASK = afe_pkg::code_t'((1 << (afe_pkg::SMP_W-1)) - 1);

  typedef enum logic [1:0] {K_SAMPLE, K_WRITE, K_READ} step_kind_e;

  typedef struct {
    step_kind_e                  kind;
    logic [afe_pkg::BUS_AW-1:0]  addr;
    logic [afe_pkg::BUS_DW-1:0]  data; // wdata, or expected rdata on reads
    logic                        err; // expected sys_err_o
    logic [7:0]                  led; // expected led_o after the access
    afe_pkg::code_t              adc_a, adc_b;
    afe_pkg::smp_t               asg_a, asg_b, pid_a, pid_b;
    afe_pkg::smp_t               exp_adc_a, exp_adc_b;
    afe_pkg::code_t              exp_dac_a, exp_dac_b;
  } step_t;

  logic                        adc_clk;
  logic                        arst_n_i;
  afe_pkg::code_t              adc_dat_a_i, adc_dat_b_i;
  afe_pkg::smp_t               asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  afe_pkg::smp_t               adc_a_o, adc_b_o;
  afe_pkg::code_t              dac_dat_a_o, dac_dat_b_o;
  logic [7:0]                  led_o;
  logic [afe_pkg::BUS_AW-1:0]  sys_addr_i;
  logic [afe_pkg::BUS_DW-1:0]  sys_wdata_i;
  logic                        sys_wen_i, sys_ren_i;
  logic [afe_pkg::BUS_DW-1:0]  sys_rdata_o;
  logic                        sys_ack_o, sys_err_o;

  int    seed; // random sample data
  step_t steps[$];

  `include "afe_tb_checks.svh"

  afe_top i_afe_top (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o),
    .asg_a_i     (asg_a_i),
    .asg_b_i     (asg_b_i),
    .pid_a_i     (pid_a_i),
    .pid_b_i     (pid_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  always #CLK_HALF adc_clk = ~adc_clk;

  //////////////////////////////
  // reference rules
  //////////////////////////////

  function automatic afe_pkg::smp_t code_to_smp(input afe_pkg::code_t c);
    return afe_pkg::smp_t'(c ^ LOW_MASK);
  endfunction

  function automatic afe_pkg::code_t smp_to_code(input afe_pkg::smp_t v);
    return afe_pkg::code_t'(v) ^ LOW_MASK;
  endfunction

  // full precision sum, clamped to the sample range
  function automatic afe_pkg::smp_t clamp_sum(input afe_pkg::smp_t a, input afe_pkg::smp_t b);
    int s;
    int hi;
    s  = int'(a) + int'(b);
    hi = (1 << (afe_pkg::SMP_W-1)) - 1;
    if (s > hi)
      s = hi;
    else if (s < -hi - 1)
      s = -hi - 1;
    return afe_pkg::smp_t'(s);
  endfunction

  //////////////////////////////
  // table building
  //////////////////////////////

  function automatic void add_sample(input logic loop, input afe_pkg::code_t adc_a,
                                     input afe_pkg::code_t adc_b, input afe_pkg::smp_t asg_a,
                                     input afe_pkg::smp_t asg_b, input afe_pkg::smp_t pid_a,
                                     input afe_pkg::smp_t pid_b);
    step_t st;
    st.kind      = K_SAMPLE;
    st.adc_a     = adc_a;
    st.adc_b     = adc_b;
    st.asg_a     = asg_a;
    st.asg_b     = asg_b;
    st.pid_a     = pid_a;
    st.pid_b     = pid_b;
    st.exp_dac_a = smp_to_code(clamp_sum(asg_a, pid_a));
    st.exp_dac_b = smp_to_code(clamp_sum(asg_b, pid_b));
    st.exp_adc_a = loop ? clamp_sum(asg_a, pid_a) : code_to_smp(adc_a); // loopback bypasses ADC
    st.exp_adc_b = loop ? clamp_sum(asg_b, pid_b) : code_to_smp(adc_b);
    steps.push_back(st);
  endfunction

  function automatic void add_random_samples(input logic loop, input int n);
    repeat (n)
      add_sample(loop, afe_pkg::code_t'($random(seed)), afe_pkg::code_t'($random(seed)),
                 afe_pkg::smp_t'($random(seed)), afe_pkg::smp_t'($random(seed)),
                 afe_pkg::smp_t'($random(seed)), afe_pkg::smp_t'($random(seed)));
  endfunction

  function automatic void add_bus(input step_kind_e kind, input logic [31:0] addr,
                                  input logic [31:0] data, input logic err,
                                  input logic [7:0] led);
    step_t st;
    st.kind = kind;
    st.addr = addr;
    st.data = data;
    st.err  = err;
    st.led  = led;
    steps.push_back(st);
  endfunction

  task automatic build_table;
    logic [31:0] a_id;
    logic [31:0] a_loop;
    logic [31:0] a_led;
    a_id   = 32'(afe_pkg::HK_ID);
    a_loop = 32'(afe_pkg::HK_LOOP);
    a_led  = 32'(afe_pkg::HK_LED);
    // conversion corners and saturation in both directions
    add_sample(1'b0, 14'h0000, 14'h3FFF, 14'sd100, 14'sd8000, 14'sd200, 14'sd1000);
    add_sample(1'b0, 14'h1FFF, 14'h2000, -14'sd8000, -14'sd8192, -14'sd1000, -14'sd8192);
    add_sample(1'b0, 14'h1234, 14'h2ABC, 14'sd8191, 14'sd8191, -14'sd8192, 14'sd8191);
    add_random_samples(1'b0, 8);
    // housekeeping
    add_bus(K_READ, a_id, afe_pkg::HK_ID_VAL, 1'b0, 8'h00);
    add_bus(K_READ, a_loop, 32'h0, 1'b0, 8'h00);
    add_bus(K_WRITE, a_led, 32'hDEAD_01A5, 1'b0, 8'hA5); // only low byte lands
    add_bus(K_READ, a_led, 32'h0000_00A5, 1'b0, 8'hA5);
    add_bus(K_WRITE, a_led, 32'h0000_013C, 1'b0, 8'h3C);
    add_bus(K_READ, a_led, 32'h0000_003C, 1'b0, 8'h3C);
    // error cases leave registers alone
    add_bus(K_WRITE, a_id, 32'h1234_5678, 1'b1, 8'h3C);
    add_bus(K_READ, a_id, afe_pkg::HK_ID_VAL, 1'b0, 8'h3C);
    add_bus(K_WRITE, 32'h0000_000C, 32'hFFFF_FFFF, 1'b1, 8'h3C);
    add_bus(K_READ, 32'h0000_0010, 32'h0, 1'b1, 8'h3C);
    // empty regions, including one aimed at the LED offset
    for (int r = 1; r < afe_pkg::N_REGIONS; r++)
      add_bus(K_READ, (r << afe_pkg::REGION_LSB) | a_led, 32'h0, 1'b0, 8'h3C);
    add_bus(K_WRITE, (32'd3 << afe_pkg::REGION_LSB) | a_led, 32'hFF, 1'b0, 8'h3C);
    add_bus(K_READ, a_led, 32'h0000_003C, 1'b0, 8'h3C);
    add_bus(K_READ, a_loop, 32'h0, 1'b0, 8'h3C);
    // loopback on, ADC codes must be ignored
    add_bus(K_WRITE, a_loop, 32'h1, 1'b0, 8'h3C);
    add_bus(K_READ, a_loop, 32'h1, 1'b0, 8'h3C);
    add_sample(1'b1, 14'h0000, 14'h3FFF, 14'sd5000, -14'sd5000, 14'sd5000, -14'sd5000);
    add_random_samples(1'b1, 6);
    // back to normal capture
    add_bus(K_WRITE, a_loop, 32'h0, 1'b0, 8'h3C);
    add_random_samples(1'b0, 4);
  endtask

  //////////////////////////////
  // step execution
  //////////////////////////////

  // registered one edge after presentation, checked mid-cycle
  task automatic apply_sample(input step_t st);
    @(posedge adc_clk);
    adc_dat_a_i <= st.adc_a;
    adc_dat_b_i <= st.adc_b;
    asg_a_i     <= st.asg_a;
    asg_b_i     <= st.asg_b;
    pid_a_i     <= st.pid_a;
    pid_b_i     <= st.pid_b;
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_smp("adc_a_o", adc_a_o, st.exp_adc_a);
    check_smp("adc_b_o", adc_b_o, st.exp_adc_b);
    check_code("dac_dat_a_o", dac_dat_a_o, st.exp_dac_a);
    check_code("dac_dat_b_o", dac_dat_b_o, st.exp_dac_b);
  endtask

  task automatic apply_bus(input step_t st);
    logic [afe_pkg::BUS_DW-1:0] rdata;
    logic                       err;
    bus_access(st.kind == K_WRITE, st.addr, st.data, rdata, err);
    check_data("sys_rdata_o", rdata, (st.kind == K_READ) ? st.data : '0); // writes read zero
    check_flag("sys_err_o", err, st.err);
    check_led("led_o", led_o, st.led);
  endtask

  initial
  begin
    seed        = 32'h2dd5_4d71;
    adc_clk     = 1'b0;
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_a_i     = '0;
    asg_b_i     = '0;
    pid_a_i     = '0;
    pid_b_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    build_table();

    // three rising edges in reset, state checked just before release
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check_smp("adc_a_o", adc_a_o, '0);
    check_code("dac_dat_a_o", dac_dat_a_o, '0);
    check_led("led_o", led_o, 8'h00);
    check_flag("sys_ack_o", sys_ack_o, 1'b0);
    @(posedge adc_clk);
    arst_n_i <= 1'b1;

    foreach (steps[i])
    begin
      if (steps[i].kind == K_SAMPLE)
        apply_sample(steps[i]);
      else
        apply_bus(steps[i]);
    end

    $display("%0d steps run, %0d value errors, %0d bus protocol errors",
             steps.size(), value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
